// File: bench/ex_stage_tb.sv
////////////////////
// testbench for the execute stage
// random issue on all four slots, seed 46992
// expects EX_XLEN of 64, stops at the first mismatch
////////////////////
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_stage_tb;

  localparam int MULT_LAT    = `EX_MULT_STAGES;
  localparam int DRAIN_LIMIT = 50;

  // one expected result and the cycle it was issued in
  typedef struct packed {
    ex_pkg::xlen_t val;
    logic          take;
    logic [31:0]   cyc;
  } exp_t;

  logic                clock;
  logic                rst_n;
  ex_pkg::issue_t      issue_alu0, issue_alu1, issue_mult, issue_br;
  ex_pkg::xlen_t [3:0] t1_value, t2_value;
  ex_pkg::xlen_t       alu0_result, alu1_result, mult_result, br_target;
  logic                alu0_valid, alu1_valid, mult_valid, br_valid, take_branch;

  integer      seed;
  logic [31:0] cycle;
  exp_t        q_alu0[$], q_alu1[$], q_mult[$], q_br[$];
  exp_t        got;

  ex_stage i_dut (.*);

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // cycle count, read by stimulus and compare
  always @(posedge clock) cycle <= cycle + 1;

  ////////////////////
  // reference model
  ////////////////////
  function automatic void ref_operands(input ex_pkg::issue_t ins, input ex_pkg::xlen_t ra,
                                       input ex_pkg::xlen_t rb, output ex_pkg::xlen_t a,
                                       output ex_pkg::xlen_t b);
    logic [31:0] w;
    w = ins.inst_word;
    case (ins.opa_sel)
      ex_pkg::OPA_REGA:     a = ra;
      ex_pkg::OPA_MEM_DISP: a = ex_pkg::xlen_t'($signed(w[15:0]));
      ex_pkg::OPA_NPC:      a = ins.npc;
      default:              a = ~ex_pkg::xlen_t'(3);
    endcase
    case (ins.opb_sel)
      ex_pkg::OPB_REGB:    b = rb;
      ex_pkg::OPB_ALU_IMM: b = ex_pkg::xlen_t'(w[20:13]);
      default:             b = ex_pkg::xlen_t'($signed(w[20:0])) << 2;
    endcase
  endfunction

  function automatic ex_pkg::xlen_t ref_alu(input ex_pkg::alu_func_e f,
                                            input ex_pkg::xlen_t a, input ex_pkg::xlen_t b);
    logic [5:0]    sh;
    logic          ult;
    logic          eq;
    logic          lt;
    ex_pkg::xlen_t fill;
    sh  = b[5:0];
    ult = a < b;
    eq  = a == b;
    // signs differ, the negative one is smaller
    lt  = (a[63] != b[63]) ? a[63] : ult;
    // top sh bits get the sign for SRA
    fill = a[63] ? ~({64{1'b1}} >> sh) : '0;
    case (f)
      ex_pkg::ALU_ADDQ:   return a + b;
      ex_pkg::ALU_SUBQ:   return a - b;
      ex_pkg::ALU_AND:    return a & b;
      ex_pkg::ALU_BIC:    return a & ~b;
      ex_pkg::ALU_BIS:    return a | b;
      ex_pkg::ALU_ORNOT:  return a | ~b;
      ex_pkg::ALU_XOR:    return a ^ b;
      ex_pkg::ALU_EQV:    return ~(a ^ b);
      ex_pkg::ALU_SRL:    return a >> sh;
      ex_pkg::ALU_SLL:    return a << sh;
      ex_pkg::ALU_SRA:    return (a >> sh) | fill;
      ex_pkg::ALU_CMPULT: return {63'd0, ult};
      ex_pkg::ALU_CMPEQ:  return {63'd0, eq};
      ex_pkg::ALU_CMPULE: return {63'd0, ult | eq};
      ex_pkg::ALU_CMPLT:  return {63'd0, lt};
      ex_pkg::ALU_CMPLE:  return {63'd0, lt | eq};
      default:            return '0;
    endcase
  endfunction

  function automatic logic ref_cond(input logic [2:0] code, input ex_pkg::xlen_t ra);
    logic t;
    case (code[1:0])
      2'd0:    t = ~ra[0];
      2'd1:    t = (ra == '0);
      2'd2:    t = ra[63];
      default: t = ra[63] | (ra == '0);
    endcase
    return t ^ code[2];
  endfunction

  // full 128-bit product, keep the low word
  function automatic ex_pkg::xlen_t ref_mult(input ex_pkg::xlen_t a, input ex_pkg::xlen_t b);
    logic [127:0] full;
    full = {64'd0, a} * {64'd0, b};
    return full[63:0];
  endfunction

  ////////////////////
  // checks
  ////////////////////
  task automatic abort_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic stop_with_fail(input string why);
    $display("%s at %0t", why, $time);
    abort_run();
  endtask

  task automatic check_word(input string name, input ex_pkg::xlen_t exp, input ex_pkg::xlen_t act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_delay(input string name, input logic [31:0] issued, input int lat);
    if (cycle - issued != lat) begin
      stop_with_fail($sformatf("%s result came %0d cycles after issue instead of %0d",
                               name, cycle - issued, lat));
    end
  endtask

  // outputs settle after the rising edge, sample them on the falling one
  always @(negedge clock) begin
    if (rst_n) begin
      if (alu0_valid) begin
        if (q_alu0.size() == 0) stop_with_fail("alu0_valid high with nothing issued");
        got = q_alu0.pop_front();
        check_delay("alu0", got.cyc, 1);
        check_word("alu0_result", got.val, alu0_result);
      end
      if (alu1_valid) begin
        if (q_alu1.size() == 0) stop_with_fail("alu1_valid high with nothing issued");
        got = q_alu1.pop_front();
        check_delay("alu1", got.cyc, 1);
        check_word("alu1_result", got.val, alu1_result);
      end
      if (mult_valid) begin
        if (q_mult.size() == 0) stop_with_fail("mult_valid high with nothing issued");
        got = q_mult.pop_front();
        check_delay("mult", got.cyc, MULT_LAT);
        check_word("mult_result", got.val, mult_result);
      end
      if (br_valid) begin
        if (q_br.size() == 0) stop_with_fail("br_valid high with nothing issued");
        got = q_br.pop_front();
        check_delay("branch", got.cyc, 1);
        check_word("br_target", got.val, br_target);
        check_bit("take_branch", got.take, take_branch);
      end
    end
  end

  ////////////////////
  // stimulus helpers
  ////////////////////

  // boundary values mixed with plain random words
  function automatic ex_pkg::xlen_t rand_word();
    case ($unsigned($random(seed)) % 8)
      0:       return '0;
      1:       return 64'h7fff_ffff_ffff_ffff;
      2:       return 64'h8000_0000_0000_0000;
      3:       return '1;
      4:       return 64'd63;
      default: return {$random(seed), $random(seed)};
    endcase
  endfunction

  // negative, zero, positive odd, positive even
  function automatic ex_pkg::xlen_t cond_operand(input logic [1:0] k);
    ex_pkg::xlen_t r;
    r = {$random(seed), $random(seed)};
    case (k)
      2'd0:    return r | 64'h8000_0000_0000_0000;
      2'd1:    return '0;
      2'd2:    return {1'b0, r[62:1], 1'b1};
      default: return {1'b0, r[62:2], 2'b10};
    endcase
  endfunction

  function automatic ex_pkg::issue_t rand_issue(input ex_pkg::alu_func_e f,
                                                input ex_pkg::opa_sel_e a,
                                                input ex_pkg::opb_sel_e b);
    ex_pkg::issue_t ins;
    ins               = '0;
    ins.valid         = 1'b1;
    ins.inst_word     = $random(seed);
    ins.npc           = {$random(seed), $random(seed)};
    ins.alu_func      = f;
    ins.opa_sel       = a;
    ins.opb_sel       = b;
    return ins;
  endfunction

  // npc plus branch displacement, random displacement sign
  function automatic ex_pkg::issue_t make_branch(input logic [2:0] code, input logic cond,
                                                 input logic uncond);
    ex_pkg::issue_t ins;
    ins = rand_issue(ex_pkg::ALU_ADDQ, ex_pkg::OPA_NPC, ex_pkg::OPB_BR_DISP);
    ins.inst_word[28:26] = code;
    ins.cond_branch      = cond;
    ins.uncond_branch    = uncond;
    return ins;
  endfunction

  function automatic ex_pkg::opa_sel_e rand_opa();
    return ex_pkg::opa_sel_e'($unsigned($random(seed)) % 4);
  endfunction

  function automatic ex_pkg::opb_sel_e rand_opb();
    return ex_pkg::opb_sel_e'($unsigned($random(seed)) % 3);
  endfunction

  // drive one slot and queue its expected result
  task automatic issue_slot(input ex_pkg::slot_e s, input ex_pkg::issue_t ins,
                            input ex_pkg::xlen_t ra, input ex_pkg::xlen_t rb);
    ex_pkg::xlen_t a;
    ex_pkg::xlen_t b;
    exp_t          e;
    ref_operands(ins, ra, rb, a, b);
    e.cyc       = cycle;
    e.take      = 1'b0;
    t1_value[s] = ra;
    t2_value[s] = rb;
    case (s)
      ex_pkg::SLOT_ALU0: begin
        issue_alu0 = ins;
        e.val      = ref_alu(ins.alu_func, a, b);
        q_alu0.push_back(e);
      end
      ex_pkg::SLOT_ALU1: begin
        issue_alu1 = ins;
        e.val      = ref_alu(ins.alu_func, a, b);
        q_alu1.push_back(e);
      end
      ex_pkg::SLOT_MULT: begin
        issue_mult = ins;
        e.val      = ref_mult(a, b);
        q_mult.push_back(e);
      end
      default: begin
        issue_br = ins;
        e.val    = a + b;
        e.take   = ins.uncond_branch | (ins.cond_branch & ref_cond(ins.inst_word[28:26], ra));
        q_br.push_back(e);
      end
    endcase
  endtask

  // next cycle, all slots idle unless driven again
  task automatic advance_cycle();
    @(posedge clock);
    #1;
    issue_alu0.valid = 1'b0;
    issue_alu1.valid = 1'b0;
    issue_mult.valid = 1'b0;
    issue_br.valid   = 1'b0;
  endtask

  task automatic drain_results();
    int n;
    n = 0;
    while (q_alu0.size() + q_alu1.size() + q_mult.size() + q_br.size() != 0) begin
      @(posedge clock);
      n++;
      if (n > DRAIN_LIMIT) stop_with_fail("expected results never came out");
    end
  endtask

  ////////////////////
  // test sequence
  ////////////////////
  initial begin
    int          i;
    int          f;
    int          c;
    int          k;
    logic [31:0] r;
    seed       = 46992;
    cycle      = '0;
    rst_n      = 1'b0;
    issue_alu0 = '0;
    issue_alu1 = '0;
    issue_mult = '0;
    issue_br   = '0;
    t1_value   = '0;
    t2_value   = '0;
    repeat (2) @(posedge clock);
    #1 rst_n = 1'b1;

    // idle after reset
    for (i = 0; i < 6; i++) begin
      @(negedge clock);
      check_bit("alu0_valid", 1'b0, alu0_valid);
      check_bit("alu1_valid", 1'b0, alu1_valid);
      check_bit("mult_valid", 1'b0, mult_valid);
      check_bit("br_valid", 1'b0, br_valid);
    end

    // every alu function with every operand source, both alus
    for (f = 0; f < 16; f++) begin
      for (i = 0; i < 24; i++) begin
        advance_cycle();
        issue_slot(ex_pkg::SLOT_ALU0,
                   rand_issue(ex_pkg::alu_func_e'(f), ex_pkg::opa_sel_e'(i % 4),
                              ex_pkg::opb_sel_e'((i / 4) % 3)), rand_word(), rand_word());
        issue_slot(ex_pkg::SLOT_ALU1,
                   rand_issue(ex_pkg::alu_func_e'(f), ex_pkg::opa_sel_e'(i % 4),
                              ex_pkg::opb_sel_e'((i / 4) % 3)), rand_word(), rand_word());
      end
    end

    // back to back multiplies
    for (i = 0; i < 40; i++) begin
      advance_cycle();
      issue_slot(ex_pkg::SLOT_MULT, rand_issue(ex_pkg::ALU_MULQ, rand_opa(), rand_opb()),
                 rand_word(), rand_word());
    end

    // each condition code against each class of register a
    for (c = 0; c < 8; c++) begin
      for (k = 0; k < 8; k++) begin
        advance_cycle();
        issue_slot(ex_pkg::SLOT_BR, make_branch(c[2:0], 1'b1, 1'b0),
                   cond_operand(k[1:0]), rand_word());
      end
    end
    for (k = 0; k < 16; k++) begin
      advance_cycle();
      issue_slot(ex_pkg::SLOT_BR, make_branch(k[2:0], 1'b0, 1'b1),
                 cond_operand(k[1:0]), rand_word());
    end

    // all four slots at once
    for (i = 0; i < 150; i++) begin
      advance_cycle();
      r = $random(seed);
      issue_slot(ex_pkg::SLOT_ALU0,
                 rand_issue(ex_pkg::alu_func_e'(r[3:0]), rand_opa(), rand_opb()),
                 rand_word(), rand_word());
      issue_slot(ex_pkg::SLOT_ALU1,
                 rand_issue(ex_pkg::alu_func_e'(r[7:4]), rand_opa(), rand_opb()),
                 rand_word(), rand_word());
      issue_slot(ex_pkg::SLOT_MULT, rand_issue(ex_pkg::ALU_MULQ, rand_opa(), rand_opb()),
                 rand_word(), rand_word());
      issue_slot(ex_pkg::SLOT_BR, make_branch(r[10:8], r[11], r[12]),
                 cond_operand(r[14:13]), rand_word());
    end

    advance_cycle();
    drain_results();
    // a few idle cycles catch stray valids
    repeat (4) @(posedge clock);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// File: design/ex_alu.sv
////////////////////
// integer alu, result registered, 1 cycle latency
// ALU_MULQ is not handled here and returns a marker word
////////////////////
`timescale 1ns/1ps

module ex_alu (
  input  logic          clock,
  input  logic          rst_n,
  ex_fu_if.fu           fu,
  output ex_pkg::xlen_t result,
  output logic          result_valid
);

  ex_pkg::xlen_t alu_out;
  logic [5:0]    shamt;

  // shift count from low six bits of operand b
  assign shamt = fu.opb[5:0];

  ////////////////////
  // function select
  ////////////////////
  always_comb begin
    case (fu.func)
      ex_pkg::ALU_ADDQ:   alu_out = fu.opa + fu.opb;
      ex_pkg::ALU_SUBQ:   alu_out = fu.opa - fu.opb;
      ex_pkg::ALU_AND:    alu_out = fu.opa & fu.opb;
      ex_pkg::ALU_BIC:    alu_out = fu.opa & ~fu.opb;
      ex_pkg::ALU_BIS:    alu_out = fu.opa | fu.opb;
      ex_pkg::ALU_ORNOT:  alu_out = fu.opa | ~fu.opb;
      ex_pkg::ALU_XOR:    alu_out = fu.opa ^ fu.opb;
      ex_pkg::ALU_EQV:    alu_out = fu.opa ^ ~fu.opb;
      // logical shifts fill with zero
      ex_pkg::ALU_SRL:    alu_out = fu.opa >> shamt;
      ex_pkg::ALU_SLL:    alu_out = fu.opa << shamt;
      // arithmetic shift copies bit 63
      ex_pkg::ALU_SRA:    alu_out = $signed(fu.opa) >>> shamt;
      // compares give 0 or 1 in bit 0
      ex_pkg::ALU_CMPULT: alu_out = ex_pkg::xlen_t'(fu.opa < fu.opb);
      ex_pkg::ALU_CMPEQ:  alu_out = ex_pkg::xlen_t'(fu.opa == fu.opb);
      ex_pkg::ALU_CMPULE: alu_out = ex_pkg::xlen_t'(fu.opa <= fu.opb);
      ex_pkg::ALU_CMPLT:  alu_out = ex_pkg::xlen_t'($signed(fu.opa) < $signed(fu.opb));
      ex_pkg::ALU_CMPLE:  alu_out = ex_pkg::xlen_t'($signed(fu.opa) <= $signed(fu.opb));
      // multiply belongs to ex_mult
      default:            alu_out = ex_pkg::xlen_t'(64'hdead_beef_baad_beef);
    endcase
  end

  ////////////////////
  // output register
  ////////////////////

  // valid bit
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= fu.valid;
    end
  end

  // result only loads on a valid slot
  always_ff @(posedge clock) begin
    if (fu.valid) begin
      result <= alu_out;
    end
  end

endmodule

// File: design/ex_branch_unit.sv
////////////////////
// branch condition, take decision and target
// condition is always tested on register a
// target = opa + opb, decode selects npc and branch disp
////////////////////
`timescale 1ns/1ps

module ex_branch_unit (
  input  logic          clock,
  input  logic          rst_n,
  ex_fu_if.fu           fu,
  input  ex_pkg::xlen_t rega,
  input  logic [2:0]    cond_code,
  input  logic          cond_branch,
  input  logic          uncond_branch,
  output logic          take_branch,
  output ex_pkg::xlen_t target,
  output logic          br_valid
);

  logic cond;
  logic take_next;

  // code bits 1..0 pick the test, bit 2 inverts it
  always_comb begin
    case (cond_code[1:0])
      // LBC, low bit clear
      2'b00:   cond = ~rega[0];
      // EQ
      2'b01:   cond = (rega == '0);
      // LT, sign bit set
      2'b10:   cond = ($signed(rega) < 0);
      // LE
      default: cond = ($signed(rega) <= 0);
    endcase
    if (cond_code[2]) begin
      cond = ~cond;
    end
  end

  // unconditional, or conditional with the test true
  assign take_next = uncond_branch | (cond_branch & cond);

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      br_valid    <= 1'b0;
      take_branch <= 1'b0;
    end else begin
      br_valid    <= fu.valid;
      take_branch <= fu.valid & take_next;
    end
  end

  // target only loads on a valid slot
  always_ff @(posedge clock) begin
    if (fu.valid) begin
      target <= fu.opa + fu.opb;
    end
  end

endmodule

// File: design/ex_fu_if.sv
////////////////////
// operand bundle from operand select to one functional unit
// no handshake, valid alone marks a transfer
////////////////////
`timescale 1ns/1ps

interface ex_fu_if;

  // slot holds an instruction this cycle
  logic                valid;
  // selected operands
  ex_pkg::xlen_t       opa;
  ex_pkg::xlen_t       opb;
  // alu function, ignored by the multiplier
  ex_pkg::alu_func_e   func;

  // operand select side
  modport src (
    output valid, opa, opb, func
  );

  // functional unit side, accepts every valid cycle
  modport fu (
    input valid, opa, opb, func
  );

endinterface

// File: design/ex_mult.sv
////////////////////
// pipelined multiplier, low 64 bits of the product
// one chunk of the multiplier per stage, new pair every cycle
// latency EX_MULT_STAGES, results leave in issue order
////////////////////
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_mult (
  input  logic          clock,
  input  logic          rst_n,
  ex_fu_if.fu           fu,
  output ex_pkg::xlen_t product,
  output logic          product_valid
);

  localparam int STAGES = `EX_MULT_STAGES;
  // multiplier bits consumed per stage
  localparam int CHUNK  = `EX_XLEN / STAGES;

  // stage inputs, element 0 comes straight from the slot
  ex_pkg::xlen_t mcand  [STAGES];
  ex_pkg::xlen_t mplier [STAGES];
  // stage outputs
  ex_pkg::xlen_t sum_q   [STAGES];
  logic          valid_q [STAGES];

  assign mcand[0]  = fu.opa;
  assign mplier[0] = fu.opb;

  for (genvar s = 0; s < STAGES; s++) begin : g_stage
    ex_pkg::xlen_t    sum_in;
    logic             valid_in;
    logic [CHUNK-1:0] chunk;

    // first stage starts from an empty sum
    if (s == 0) begin : g_first
      assign sum_in   = '0;
      assign valid_in = fu.valid;
    end else begin : g_next
      assign sum_in   = sum_q[s-1];
      assign valid_in = valid_q[s-1];
    end

    // lowest remaining multiplier bits
    assign chunk = mplier[s][CHUNK-1:0];

    // valid bit walks with its operands
    always_ff @(posedge clock) begin
      if (!rst_n) begin
        valid_q[s] <= 1'b0;
      end else begin
        valid_q[s] <= valid_in;
      end
    end

    // running sum plus this chunk's partial product
    // truncated to the data width
    always_ff @(posedge clock) begin
      sum_q[s] <= sum_in + mcand[s] * chunk;
    end

    // multiplicand moves up, multiplier moves down
    // nothing left to forward after the last stage
    if (s < STAGES - 1) begin : g_fwd
      always_ff @(posedge clock) begin
        mcand[s+1]  <= mcand[s] << CHUNK;
        mplier[s+1] <= mplier[s] >> CHUNK;
      end
    end
  end

  ////////////////////
  // output
  ////////////////////
  assign product       = sum_q[STAGES-1];
  assign product_valid = valid_q[STAGES-1];

endmodule

// File: design/ex_operand_sel.sv
////////////////////
// operand a/b select for one issue slot
// purely combinational
// immediate fields assume a 64-bit data path
////////////////////
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_operand_sel (
  input  ex_pkg::issue_t issue,
  input  ex_pkg::xlen_t  rega,
  input  ex_pkg::xlen_t  regb,
  ex_fu_if.src           fu
);

  ex_pkg::xlen_t mem_disp;
  ex_pkg::xlen_t br_disp;
  ex_pkg::xlen_t alu_imm;

  ////////////////////
  // immediates
  ////////////////////

  // memory format displacement, 16 bits signed
  assign mem_disp = {{(`EX_XLEN-16){issue.inst_word[15]}}, issue.inst_word[15:0]};
  // branch displacement, 21 bits signed, word aligned
  assign br_disp  = {{(`EX_XLEN-23){issue.inst_word[20]}}, issue.inst_word[20:0], 2'b00};
  // operate format literal, 8 bits unsigned
  assign alu_imm  = {{(`EX_XLEN-8){1'b0}}, issue.inst_word[20:13]};

  ////////////////////
  // operand muxes
  ////////////////////

  // all four codes are used, NOT3 sits on the default arm
  always_comb begin
    case (issue.opa_sel)
      ex_pkg::OPA_REGA:     fu.opa = rega;
      ex_pkg::OPA_MEM_DISP: fu.opa = mem_disp;
      ex_pkg::OPA_NPC:      fu.opa = issue.npc;
      default:              fu.opa = ~ex_pkg::xlen_t'(3);
    endcase
  end

  // marker word shows up on a bad select code
  always_comb begin
    fu.opb = ex_pkg::xlen_t'(64'hbaad_beef_dead_beef);
    case (issue.opb_sel)
      ex_pkg::OPB_REGB:    fu.opb = regb;
      ex_pkg::OPB_ALU_IMM: fu.opb = alu_imm;
      ex_pkg::OPB_BR_DISP: fu.opb = br_disp;
      default:             ;
    endcase
  end

  // control passes straight through
  assign fu.valid = issue.valid;
  assign fu.func  = issue.alu_func;

endmodule

// File: design/ex_pkg.sv
////////////////////
// shared types of the execute stage
// xlen_t follows EX_XLEN from ex_cfg.svh
// enum encodings are internal to this core
////////////////////
`include "ex_cfg.svh"

package ex_pkg;

  // one data word
  typedef logic [`EX_XLEN-1:0] xlen_t;

  // alu function codes, same set the decoder emits
  // ALU_MULQ goes to the multiplier slot only
  typedef enum logic [4:0] {
    ALU_ADDQ   = 5'h00,
    ALU_SUBQ   = 5'h01,
    ALU_AND    = 5'h02,
    ALU_BIC    = 5'h03,
    ALU_BIS    = 5'h04,
    ALU_ORNOT  = 5'h05,
    ALU_XOR    = 5'h06,
    ALU_EQV    = 5'h07,
    ALU_SRL    = 5'h08,
    ALU_SLL    = 5'h09,
    ALU_SRA    = 5'h0a,
    ALU_CMPULT = 5'h0b,
    ALU_CMPEQ  = 5'h0c,
    ALU_CMPULE = 5'h0d,
    ALU_CMPLT  = 5'h0e,
    ALU_CMPLE  = 5'h0f,
    ALU_MULQ   = 5'h10
  } alu_func_e;

  // operand a sources
  typedef enum logic [1:0] {
    OPA_REGA     = 2'd0,
    OPA_MEM_DISP = 2'd1,
    OPA_NPC      = 2'd2,
    OPA_NOT3     = 2'd3
  } opa_sel_e;

  // operand b sources, code 3 unused
  typedef enum logic [1:0] {
    OPB_REGB    = 2'd0,
    OPB_ALU_IMM = 2'd1,
    OPB_BR_DISP = 2'd2
  } opb_sel_e;

  // functional unit slots, also the index into the register value arrays
  typedef enum logic [1:0] {
    SLOT_ALU0 = 2'd0,
    SLOT_ALU1 = 2'd1,
    SLOT_MULT = 2'd2,
    SLOT_BR   = 2'd3
  } slot_e;

  // one issued instruction as it leaves the issue register
  typedef struct packed {
    logic        valid;
    logic [31:0] inst_word;
    xlen_t       npc;
    alu_func_e   alu_func;
    opa_sel_e    opa_sel;
    opb_sel_e    opb_sel;
    logic        cond_branch;
    logic        uncond_branch;
  } issue_t;

endpackage

// File: design/ex_stage.sv
////////////////////
// execute stage top, four slots, no back-pressure
// slots: alu0, alu1, multiplier, branch unit
// consumer must take every result on its valid cycle
////////////////////
`timescale 1ns/1ps

module ex_stage (
  input  logic                clock,
  input  logic                rst_n,
  // issued instructions, one per functional unit
  input  ex_pkg::issue_t      issue_alu0,
  input  ex_pkg::issue_t      issue_alu1,
  input  ex_pkg::issue_t      issue_mult,
  input  ex_pkg::issue_t      issue_br,
  // register operands, indexed by ex_pkg::slot_e
  input  ex_pkg::xlen_t [3:0] t1_value,
  input  ex_pkg::xlen_t [3:0] t2_value,
  // results
  output ex_pkg::xlen_t       alu0_result,
  output ex_pkg::xlen_t       alu1_result,
  output ex_pkg::xlen_t       mult_result,
  output ex_pkg::xlen_t       br_target,
  output logic                alu0_valid,
  output logic                alu1_valid,
  output logic                mult_valid,
  output logic                br_valid,
  output logic                take_branch
);

  // one operand bundle per slot
  ex_fu_if alu0_fu ();
  ex_fu_if alu1_fu ();
  ex_fu_if mult_fu ();
  ex_fu_if br_fu ();

  ////////////////////
  // operand select
  ////////////////////
  ex_operand_sel u_sel_alu0 (
    .issue (issue_alu0),
    .rega  (t1_value[ex_pkg::SLOT_ALU0]),
    .regb  (t2_value[ex_pkg::SLOT_ALU0]),
    .fu    (alu0_fu)
  );

  ex_operand_sel u_sel_alu1 (
    .issue (issue_alu1),
    .rega  (t1_value[ex_pkg::SLOT_ALU1]),
    .regb  (t2_value[ex_pkg::SLOT_ALU1]),
    .fu    (alu1_fu)
  );

  ex_operand_sel u_sel_mult (
    .issue (issue_mult),
    .rega  (t1_value[ex_pkg::SLOT_MULT]),
    .regb  (t2_value[ex_pkg::SLOT_MULT]),
    .fu    (mult_fu)
  );

  ex_operand_sel u_sel_br (
    .issue (issue_br),
    .rega  (t1_value[ex_pkg::SLOT_BR]),
    .regb  (t2_value[ex_pkg::SLOT_BR]),
    .fu    (br_fu)
  );

  ////////////////////
  // functional units
  ////////////////////

  // alu1 also serves address generation
  ex_alu u_alu0 (
    .clock        (clock),
    .rst_n        (rst_n),
    .fu           (alu0_fu),
    .result       (alu0_result),
    .result_valid (alu0_valid)
  );

  ex_alu u_alu1 (
    .clock        (clock),
    .rst_n        (rst_n),
    .fu           (alu1_fu),
    .result       (alu1_result),
    .result_valid (alu1_valid)
  );

  ex_mult u_mult (
    .clock         (clock),
    .rst_n         (rst_n),
    .fu            (mult_fu),
    .product       (mult_result),
    .product_valid (mult_valid)
  );

  // condition code from instruction bits 28..26
  ex_branch_unit u_branch (
    .clock         (clock),
    .rst_n         (rst_n),
    .fu            (br_fu),
    .rega          (t1_value[ex_pkg::SLOT_BR]),
    .cond_code     (issue_br.inst_word[28:26]),
    .cond_branch   (issue_br.cond_branch),
    .uncond_branch (issue_br.uncond_branch),
    .take_branch   (take_branch),
    .target        (br_target),
    .br_valid      (br_valid)
  );

endmodule

// File: include/ex_cfg.svh
////////////////////
// build-time sizes for the execute stage
// EX_XLEN stays 64, the immediate bit fields assume it
// EX_MULT_STAGES must divide 64 (1, 2, 4 or 8)
////////////////////
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// data path width in bits
`define EX_XLEN 64

// multiplier pipeline depth
// one 64/N-bit chunk of the multiplier per stage
`define EX_MULT_STAGES 4

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# builds the execute stage testbench with Verilator, runs it, scans the log
cd "$(dirname "$0")" || exit 1
mkdir -p build
verilator --binary --timing -Wno-fatal -f vlog.f --top-module ex_stage_tb -Mdir build/obj \
  > build/compile.log 2>&1 \
  || { cat build/compile.log; echo "build failed"; exit 1; }
./build/obj/Vex_stage_tb > build/sim.log 2>&1
cat build/sim.log
grep -q "Simulation finished: FAIL" build/sim.log && { echo "test failed"; exit 1; }
grep -q "Simulation finished: PASS" build/sim.log || { echo "no result in log"; exit 1; }
echo "test passed"
exit 0

// File: vlog.f
+incdir+include
design/ex_pkg.sv
design/ex_fu_if.sv
design/ex_operand_sel.sv
design/ex_alu.sv
design/ex_mult.sv
design/ex_branch_unit.sv
design/ex_stage.sv
bench/ex_stage_tb.sv
